//--- Bender.yml
package:
  name: pri_mixer

sources:
  - files:
      - verilog/pri_pkg.sv
      - verilog/pri_regs.sv
      - verilog/pri_lookup.sv
      - verilog/pri_blend.sv
      - verilog/pri_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/pri_tb.sv

//--- flist.f
verilog/pri_pkg.sv
verilog/pri_regs.sv
verilog/pri_lookup.sv
verilog/pri_blend.sv
verilog/pri_top.sv
+incdir+verif
verif/pri_tb.sv

//--- verif/pri_tb_tasks.svh
    // Reset values first and then a distinct pattern in every register.
    task automatic test_registers();
        logic [7:0] data;
        for (int i = 0; i < 16; i++) begin
            wb_read(4'(i), data);
            check_hex($sformatf("wb_dat_r[%0d]", i), data, 8'h00);
        end
        for (int i = 0; i < 16; i++) begin
            wb_write(4'(i), {4'(i), 4'(15 - i)});
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(4'(i), data);
            check_hex($sformatf("wb_dat_r[%0d]", i), data, {4'(i), 4'(15 - i)});
        end
    endtask

    task automatic test_priority();
        for (int bgg = 0; bgg < 4; bgg++) begin
            program_cfg(16'hC840, 16'hB730, 16'hA620, 8'(bgg << 6), 8'h00);
            for (int g0 = 0; g0 < 4; g0++) begin
                for (int g1 = 0; g1 < 4; g1++) begin
                    pixel_step(make_pixel(g0, 8'h40 + g1, 5 + g0),
                               make_pixel(g1, 8'h80 + g0, 9 + g1), 6'(16 + bgg), 1'b1);
                end
            end
        end
    endtask

    // Zero pen on layer0, layer1, then both.
    task automatic test_transparency();
        program_cfg(16'hC840, 16'hB730, 16'h0000, 8'h00, 8'h00);
        for (int mode = 0; mode < 3; mode++) begin
            for (int g0 = 0; g0 < 4; g0++) begin
                for (int g1 = 0; g1 < 4; g1++) begin
                    pixel_step(make_pixel(g0, 8'h21 + g1, (mode != 1) ? 0 : 3),
                               make_pixel(g1, 8'h92 + g0, (mode != 0) ? 0 : 7), 6'h2A, 1'b1);
                end
            end
        end
    endtask

    // Levels 0, 1, 2 and F give adjacent pairs that include the wrap.
    task automatic test_blend();
        for (int pass = 0; pass < 2; pass++) begin
            program_cfg(16'hF210, 16'hF210, 16'h0000, 8'h00, (pass == 0) ? 8'hC0 : 8'h40);
            for (int g0 = 0; g0 < 4; g0++) begin
                for (int g1 = 0; g1 < 4; g1++) begin
                    pixel_step(make_pixel(g0, 8'h10 + g1, 1 + g0),
                               make_pixel(g1, 8'hE0 + g0, 8 + g1), 6'h15, 1'b1);
                end
            end
        end
    endtask

    task automatic test_stall();
        program_cfg(16'h3210, 16'h2301, 16'h1111, 8'h40, 8'h00);
        for (int k = 0; k < 8; k++) begin
            pixel_step(pixel_t'(14'($urandom)), pixel_t'(14'($urandom)), 6'($urandom), 1'b1);
            stall_cycles(1 + k % 4);
        end
    endtask

    task automatic test_random();
        logic [7:0] ctrl;
        for (int blk = 0; blk < n_random / 25; blk++) begin
            ctrl = 8'($urandom);
            if (blk % 2 == 0) begin
                ctrl[7:6] = 2'b11;
            end
            program_cfg(16'($urandom), 16'($urandom), 16'($urandom), 8'($urandom), ctrl);
            for (int k = 0; k < 25; k++) begin
                pixel_step(pixel_t'(14'($urandom)), pixel_t'(14'($urandom)),
                           6'($urandom), 1'b1);
            end
        end
    endtask

//--- verif/pri_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pri_tb import pri_pkg::*; ();

    localparam int clk_half    = 20;
    localparam int n_random    = 200;
    localparam int stall_limit = 8;
    localparam int wb_ops      = 48 + 8 * 20;  // Register test plus up to 20 reprograms.
    localparam int pixel_ops   = 64 + 48 + 32 + 40 + n_random + 2 * 20;
    localparam int max_cycles  = 2 * (5 + 3 * wb_ops + pixel_ops);

    logic               clk;
    logic               reset;
    logic               ce_pixel;
    pixel_t             layer0;
    pixel_t             layer1;
    logic [BG_W-1:0]    bg;
    logic [COLOR_W-1:0] color_out;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [3:0]         wb_adr;
    logic [7:0]         wb_dat_w;
    logic [7:0]         wb_dat_r;
    logic               wb_ack;

    int                 errors = 0;
    int                 checks = 0;
    int                 cycle_count = 0;
    logic [7:0]         shadow [16];   // Expected register contents.
    logic [COLOR_W:0]   pipe_q [$];    // Tracked flag and expected colour per pixel.

    pri_top #(
        .COLOR_W (COLOR_W)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .ce_pixel  (ce_pixel),
        .layer0    (layer0),
        .layer1    (layer1),
        .bg        (bg),
        .color_out (color_out),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    // Mixed colour from the shadow registers and the priority rules.
    function automatic logic [COLOR_W-1:0] expected_color(input pixel_t a, input pixel_t b,
                                                          input logic [BG_W-1:0] bgc);
        logic [15:0] t0;
        logic [15:0] t1;
        logic [15:0] t2;
        logic [3:0]  q0;
        logic [3:0]  q1;
        logic [3:0]  q2;
        logic        blend;
        logic [1:0]  bgg;
        t0    = {shadow[reg_tab0_hi], shadow[reg_tab0_lo]};
        t1    = {shadow[reg_tab1_hi], shadow[reg_tab1_lo]};
        t2    = {shadow[reg_tab2_hi], shadow[reg_tab2_lo]};
        bgg   = shadow[reg_bg][7:6];
        blend = shadow[reg_ctrl][7] && shadow[reg_ctrl][6];
        q0    = 4'(t0 >> (4 * a.grp));
        q1    = 4'(t1 >> (4 * b.grp));
        q2    = 4'(t2 >> (4 * bgg));
        if (blend && q1 == 4'(q0 - 1) && b.pen != 0) begin
            return {b.grp, b.body, a.pen};
        end
        if (blend && q1 == 4'(q0 + 1) && a.pen != 0) begin
            return {a.grp, a.body, b.pen};
        end
        if (q1 > q0) begin
            return (q2 > q1 || b.pen == 0) ? COLOR_W'(bgc) : COLOR_W'(b);
        end
        return (q2 > q0 || a.pen == 0) ? COLOR_W'(bgc) : COLOR_W'(a);
    endfunction

    function automatic pixel_t make_pixel(input int grp, input int body, input int pen);
        pixel_t p;
        p.grp  = 2'(grp);
        p.body = 8'(body);
        p.pen  = 4'(pen);
        return p;
    endfunction

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < stall_limit);
        rdat   = wb_dat_r;  // Valid while ack is high.
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        checks++;
        assert (wb_ack) else begin
            errors++;
            $display("Wishbone access to address %0d was never acknowledged", adr);
        end
        @(posedge clk);
        #1;
        checks++;
        assert (!wb_ack) else begin
            errors++;
            $display("Wishbone ack for address %0d stayed high longer than one clock", adr);
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        wb_access(1'b1, adr, data, unused);
        shadow[adr] = data;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [7:0] data);
        wb_access(1'b0, adr, 8'h00, data);
    endtask

    // One pixel enable that also checks the pixel entered two enables earlier.
    task automatic pixel_step(input pixel_t p0, input pixel_t p1, input logic [BG_W-1:0] b,
                              input bit track);
        logic [COLOR_W:0] front;
        layer0   = p0;
        layer1   = p1;
        bg       = b;
        ce_pixel = 1'b1;
        pipe_q.push_back({track, expected_color(p0, p1, b)});
        @(posedge clk);
        #1;
        ce_pixel = 1'b0;
        if (pipe_q.size() == 2) begin
            front = pipe_q.pop_front();
            if (front[COLOR_W]) begin
                check_hex("color_out", color_out, front[COLOR_W-1:0]);
            end
        end
    endtask

    task automatic flush_pipe();
        pixel_step('0, '0, '0, 1'b0);
        pixel_step('0, '0, '0, 1'b0);
    endtask

    // Enable low for n clocks with junk on the pixel inputs.
    task automatic stall_cycles(input int n);
        logic [COLOR_W-1:0] held;
        held     = color_out;
        ce_pixel = 1'b0;
        layer0   = pixel_t'(14'($urandom));
        layer1   = pixel_t'(14'($urandom));
        bg       = 6'($urandom);
        repeat (n) begin
            @(posedge clk);
            #1;
            check_hex("color_out while stalled", color_out, held);
        end
    endtask

    task automatic program_cfg(input logic [15:0] t0, input logic [15:0] t1,
                               input logic [15:0] t2, input logic [7:0] bg_reg,
                               input logic [7:0] ctrl);
        flush_pipe();
        wb_write(reg_ctrl, ctrl);
        wb_write(reg_bg, bg_reg);
        wb_write(reg_tab0_lo, t0[7:0]);
        wb_write(reg_tab0_hi, t0[15:8]);
        wb_write(reg_tab1_lo, t1[7:0]);
        wb_write(reg_tab1_hi, t1[15:8]);
        wb_write(reg_tab2_lo, t2[7:0]);
        wb_write(reg_tab2_hi, t2[15:8]);
    endtask

`include "pri_tb_tasks.svh"

    initial begin
        void'($urandom(61017));
        reset    = 1'b1;
        ce_pixel = 1'b0;
        layer0   = '0;
        layer1   = '0;
        bg       = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_hex("color_out", color_out, 0);
        check_hex("wb_ack", wb_ack, 0);

        test_registers();
        test_priority();
        test_transparency();
        test_blend();
        test_stall();
        test_random();
        flush_pipe();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pri_blend.sv
`timescale 1ns/1ns
`default_nettype none

module pri_blend import pri_pkg::*; #(
    parameter int COLOR_W = pri_pkg::COLOR_W
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ce_pixel,

    input  staged_t            stage,
    input  logic               blend_en,

    output logic [COLOR_W-1:0] color_out
);

    logic [3:0]         p0_dn;
    logic [3:0]         p0_up;
    logic               pen0_on;
    logic               pen1_on;
    mix_sel_t           mix_sel;
    logic [COLOR_W-1:0] mix_color;

    assign p0_dn   = stage.p0 - 4'd1;  // Wraps modulo 16.
    assign p0_up   = stage.p0 + 4'd1;
    assign pen0_on = |stage.l0.pen;
    assign pen1_on = |stage.l1.pen;

    // Priority decision where the first match wins.
    always_comb begin
        mix_sel = mix_l0;
        if (blend_en && (stage.p1 == p0_dn) && pen1_on) begin
            mix_sel = mix_l1_body_l0_pen;
        end else if (blend_en && (stage.p1 == p0_up) && pen0_on) begin
            mix_sel = mix_l0_body_l1_pen;
        end else if (stage.p1 > stage.p0) begin
            if ((stage.p2 > stage.p1) || !pen1_on) begin
                mix_sel = mix_bg;
            end else begin
                mix_sel = mix_l1;
            end
        end else begin
            if ((stage.p2 > stage.p0) || !pen0_on) begin
                mix_sel = mix_bg;  // Layer0 covered or transparent.
            end else begin
                mix_sel = mix_l0;
            end
        end
    end

    // Colour for the chosen mix.
    always_comb begin
        case (mix_sel)
            mix_l1: begin
                mix_color = COLOR_W'(stage.l1);
            end
            mix_bg: begin
                mix_color = COLOR_W'(stage.bg);  // Zero-extended.
            end
            mix_l1_body_l0_pen: begin
                mix_color = COLOR_W'({stage.l1.grp, stage.l1.body, stage.l0.pen});
            end
            mix_l0_body_l1_pen: begin
                mix_color = COLOR_W'({stage.l0.grp, stage.l0.body, stage.l1.pen});
            end
            default: begin
                mix_color = COLOR_W'(stage.l0);
            end
        endcase
    end

    // Second stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            color_out <= '0;
        end else if (ce_pixel) begin
            color_out <= mix_color;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pri_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module pri_lookup import pri_pkg::*; #(
    parameter int COLOR_W = pri_pkg::COLOR_W
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            ce_pixel,

    input  pixel_t          layer0,
    input  pixel_t          layer1,
    input  logic [BG_W-1:0] bg,
    input  prio_cfg_t       cfg,

    output staged_t         stage
);

    // Group select sits in the top two bits of the colour word.
    logic [COLOR_W-1:0] word0;
    logic [COLOR_W-1:0] word1;
    logic [1:0]         grp0;
    logic [1:0]         grp1;
    staged_t            stage_d;

    function automatic logic [3:0] level_of(input logic [15:0] tab, input logic [1:0] grp);
        return tab[4*grp +: 4];
    endfunction

    assign word0 = COLOR_W'(layer0);
    assign word1 = COLOR_W'(layer1);
    assign grp0  = word0[COLOR_W-1 -: 2];
    assign grp1  = word1[COLOR_W-1 -: 2];

    always_comb begin
        stage_d    = '0;
        stage_d.l0 = layer0;
        stage_d.l1 = layer1;
        stage_d.bg = bg;
        stage_d.p0 = level_of(cfg.prio_tab0, grp0);
        stage_d.p1 = level_of(cfg.prio_tab1, grp1);
        stage_d.p2 = level_of(cfg.prio_tab2, cfg.bg_grp);  // Group from control reg.
    end

    // First stage holds while the pixel enable is low.
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else if (ce_pixel) begin
            stage <= stage_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pri_pkg.sv
`default_nettype none

package pri_pkg;

    // Colour word width of the two main layers.
    localparam int COLOR_W = 14;

    // Background layer colour width.
    localparam int BG_W = 6;

    // Depth of the control register bank.
    localparam int reg_count = 16;

    // Register map.
    localparam logic [3:0] reg_ctrl    = 4'd0;  // Bits 7 and 6 set enable blend.
    localparam logic [3:0] reg_bg      = 4'd1;  // Bits 7:6 are the background group.
    localparam logic [3:0] reg_tab0_lo = 4'd4;
    localparam logic [3:0] reg_tab0_hi = 4'd5;
    localparam logic [3:0] reg_tab1_lo = 4'd6;
    localparam logic [3:0] reg_tab1_hi = 4'd7;
    localparam logic [3:0] reg_tab2_lo = 4'd8;
    localparam logic [3:0] reg_tab2_hi = 4'd9;

    // One layer pixel with the MSB first as it sits in the colour word.
    typedef struct packed {
        logic [1:0] grp;   // Priority group select.
        logic [7:0] body;  // Palette upper bits.
        logic [3:0] pen;   // Zero is transparent.
    } pixel_t;

    // Decoded control fields from the register bank.
    typedef struct packed {
        logic [15:0] prio_tab0;  // Four 4-bit levels indexed by group.
        logic [15:0] prio_tab1;
        logic [15:0] prio_tab2;
        logic [1:0]  bg_grp;
        logic        blend_en;
    } prio_cfg_t;

    // Pixels and their levels between the lookup and blend stages.
    typedef struct packed {
        pixel_t          l0;
        pixel_t          l1;
        logic [BG_W-1:0] bg;
        logic [3:0]      p0;
        logic [3:0]      p1;
        logic [3:0]      p2;
    } staged_t;

    // Mix decision of the blend stage.
    typedef enum logic [2:0] {
        mix_l0,
        mix_l1,
        mix_bg,
        mix_l1_body_l0_pen,
        mix_l0_body_l1_pen
    } mix_sel_t;

endpackage

`default_nettype wire

//--- verilog/pri_regs.sv
`timescale 1ns/1ns
`default_nettype none

module pri_regs import pri_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [3:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,

    output prio_cfg_t  cfg
);

    logic [7:0] regs [reg_count];

    logic       wb_valid;
    logic       wb_take;   // Accepted this clock.
    logic       wr_en;
    logic       rd_en;

    assign wb_valid = wb_cyc && wb_stb;
    assign wb_take  = wb_valid && !wb_ack;
    assign wr_en    = wb_take && wb_we;
    assign rd_en    = wb_take && !wb_we;

    // Single-cycle acknowledge pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_take;
        end
    end

    // Register bank.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (wr_en) begin
            regs[wb_adr] <= wb_dat_w;
        end
    end

    // Readback data holds while ack is high.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            wb_dat_r <= regs[wb_adr];
        end
    end

    // Decoded control fields.
    always_comb begin
        cfg           = '0;
        cfg.prio_tab0 = {regs[reg_tab0_hi], regs[reg_tab0_lo]};
        cfg.prio_tab1 = {regs[reg_tab1_hi], regs[reg_tab1_lo]};
        cfg.prio_tab2 = {regs[reg_tab2_hi], regs[reg_tab2_lo]};
        cfg.bg_grp    = regs[reg_bg][7:6];
        cfg.blend_en  = regs[reg_ctrl][7] & regs[reg_ctrl][6];  // Both bits needed.
    end

endmodule

`default_nettype wire

//--- verilog/pri_top.sv
`timescale 1ns/1ns
`default_nettype none

module pri_top import pri_pkg::*; #(
    parameter int COLOR_W = pri_pkg::COLOR_W
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ce_pixel,

    // Pixel side.
    input  pixel_t             layer0,
    input  pixel_t             layer1,
    input  logic [BG_W-1:0]    bg,
    output logic [COLOR_W-1:0] color_out,

    // Wishbone classic slave.
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [3:0]         wb_adr,
    input  logic [7:0]         wb_dat_w,
    output logic [7:0]         wb_dat_r,
    output logic               wb_ack
);

    prio_cfg_t cfg;
    staged_t   stage;

    pri_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg)
    );

    pri_lookup #(
        .COLOR_W (COLOR_W)
    ) u_lookup (
        .clk      (clk),
        .reset    (reset),
        .ce_pixel (ce_pixel),
        .layer0   (layer0),
        .layer1   (layer1),
        .bg       (bg),
        .cfg      (cfg),
        .stage    (stage)
    );

    pri_blend #(
        .COLOR_W (COLOR_W)
    ) u_blend (
        .clk       (clk),
        .reset     (reset),
        .ce_pixel  (ce_pixel),
        .stage     (stage),
        .blend_en  (cfg.blend_en),
        .color_out (color_out)
    );

endmodule

`default_nettype wire
